// File: cvt_cluster.f
+incdir+include
verilog/cvt_pkg.sv
verilog/cvt_station.sv
verilog/ftoi_convert.sv
verilog/itof_convert.sv
verilog/result_arbiter.sv
verilog/cvt_cluster.sv
bench/cvt_cluster_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP = cvt_cluster_tb
FILELIST = cvt_cluster.f
FLAGS = --binary --timing --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: include/cvt_ref.svh
`ifndef CVT_REF_SVH
`define CVT_REF_SVH

// Single to signed int, nearest with ties away from zero
function automatic logic [31:0] ref_ftoi(input logic [31:0] a);
	logic [7:0] e;
	longint unsigned m;
	longint unsigned q;
	int sh;
	e = a[30:23];
	m = {40'd0, 1'b1, a[22:0]};
	if (e == 8'hff && a[22:0] != 23'd0) return 32'h7fff_ffff;
	if (e == 8'd0) return 32'd0;
	if (e >= 8'd158) return a[31] ? 32'h8000_0000 : 32'h7fff_ffff;
	sh = 150 - int'(e);
	if (sh <= 0) q = m << -sh;
	else if (sh > 25) q = 0;
	else q = (m + (64'd1 << (sh - 1))) >> sh;  // Add half then truncate
	return a[31] ? -q[31:0] : q[31:0];
endfunction

// Signed int to single, nearest with ties to even
function automatic logic [31:0] ref_itof(input logic [31:0] a);
	logic [31:0] m;
	logic [7:0] e;
	logic g;
	logic st;
	if (a == 32'd0) return 32'd0;
	m = a[31] ? -a : a;
	e = 8'd150;
	g = 1'b0;
	st = 1'b0;
	while (m >= 32'h0100_0000) begin
		st = st | g;
		g = m[0];
		m = m >> 1;
		e = e + 8'd1;
	end
	while (m < 32'h0080_0000) begin
		m = m << 1;
		e = e - 8'd1;
	end
	if (g && (st || m[0])) m = m + 32'd1;
	if (m == 32'h0100_0000) begin
		m = m >> 1;
		e = e + 8'd1;
	end
	return {a[31], e, m[22:0]};
endfunction

`endif

// File: bench/cvt_cluster_tb.sv
`timescale 1ns/1ps

module cvt_cluster_tb;

	localparam int NTAG = 2 ** cvt_pkg::ROB_WIDTH;
	localparam int ISSUE_LIMIT = 200;  // Cycles one issue may stall
	localparam int DRAIN_LIMIT = 2000;

	logic clk, reset;
	logic ftoi_issue_valid, ftoi_issue_ready, ftoi_opd_valid;
	logic [cvt_pkg::ROB_WIDTH-1:0] ftoi_issue_tag, ftoi_opd_tag;
	logic [31:0] ftoi_opd_data;
	logic itof_issue_valid, itof_issue_ready, itof_opd_valid;
	logic [cvt_pkg::ROB_WIDTH-1:0] itof_issue_tag, itof_opd_tag;
	logic [31:0] itof_opd_data;
	logic wake_valid;
	logic [cvt_pkg::ROB_WIDTH-1:0] wake_tag;
	logic [31:0] wake_data;
	logic res_valid, res_ready;
	logic [cvt_pkg::ROB_WIDTH-1:0] res_tag;
	logic [31:0] res_data;
	cvt_pkg::dest_e res_dest;

	// Scoreboard by ROB tag
	logic [31:0] exp_data [NTAG];
	cvt_pkg::dest_e exp_dest [NTAG];
	int issued_cnt [NTAG];
	int done_cnt [NTAG];

	// Producers named on opd_tag and broadcast later on the wake-up bus
	logic [31:0] prod_val [NTAG];
	bit prod_busy [NTAG];
	logic [cvt_pkg::ROB_WIDTH-1:0] pend_q [$];
	bit wake_on;

	// Ties, saturation, infinities, NaN, denormals
	logic [31:0] ftoi_vals [$] = '{32'h3f00_0000, 32'hbf00_0000, 32'h3fc0_0000,
		32'h4020_0000, 32'hc020_0000, 32'h3eff_ffff, 32'h4f00_0000, 32'hcf00_0000,
		32'hcf00_0001, 32'h4eff_ffff, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
		32'hffc0_0001, 32'h0000_0001, 32'h807f_ffff, 32'h8000_0000};
	// Zero, extremes, round-to-even cases
	logic [31:0] itof_vals [$] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
		32'h8000_0000, 32'h7fff_ffff, 32'h0100_0001, 32'h0100_0003, 32'h0100_0002,
		32'hfeff_ffff, 32'h00ff_ffff, 32'h7fff_ffc0, 32'h0bc6_14e0};

	`include "cvt_ref.svh"

	cvt_cluster dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic give_up(input string why);
		$display("Simulation failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			give_up("value mismatch on the result or issue ports");
		end
	endtask

	function automatic logic is_ready(input bit unit);
		return unit ? itof_issue_ready : ftoi_issue_ready;
	endfunction

	function automatic int find_free(input bit used [NTAG]);
		int start;
		start = $urandom_range(NTAG - 1, 0);
		for (int i = 0; i < NTAG; i++) begin
			if (!used[(start + i) % NTAG]) begin
				return (start + i) % NTAG;
			end
		end
		return -1;
	endfunction

	function automatic int count_outstanding();
		int c;
		c = 0;
		for (int i = 0; i < NTAG; i++) begin
			c += issued_cnt[i] - done_cnt[i];
		end
		return c;
	endfunction

	function automatic logic [31:0] rand_value(input bit unit);
		logic [31:0] v;
		v = $urandom;
		if (!unit && $urandom % 2 == 1) begin
			v[30:23] = 8'(118 + $urandom % 44);  // Below one half up to past saturation
		end else if (unit && $urandom % 2 == 1) begin
			v = $signed(v) >>> ($urandom % 28);
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Drivers

	task automatic drive_issue(input bit unit, input logic [cvt_pkg::ROB_WIDTH-1:0] tag,
		input logic opd_ok, input logic [cvt_pkg::ROB_WIDTH-1:0] prod, input logic [31:0] data);
		if (unit) begin
			itof_issue_valid = 1'b1;
			itof_issue_tag = tag;
			itof_opd_valid = opd_ok;
			itof_opd_tag = prod;
			itof_opd_data = data;
		end else begin
			ftoi_issue_valid = 1'b1;
			ftoi_issue_tag = tag;
			ftoi_opd_valid = opd_ok;
			ftoi_opd_tag = prod;
			ftoi_opd_data = data;
		end
	endtask

	// Next cycle, strobes cleared, maybe a wake-up for a pending producer
	task automatic advance();
		int idx;
		logic [cvt_pkg::ROB_WIDTH-1:0] p;
		@(posedge clk);
		#2;
		ftoi_issue_valid = 1'b0;
		itof_issue_valid = 1'b0;
		wake_valid = 1'b0;
		if (wake_on && pend_q.size() > 0 && $urandom % 3 == 0) begin
			idx = $urandom_range(pend_q.size() - 1, 0);
			p = pend_q[idx];
			pend_q.delete(idx);
			prod_busy[p] = 1'b0;
			wake_valid = 1'b1;
			wake_tag = p;
			wake_data = prod_val[p];
		end
	endtask

	// Mode 0 operand ready, 1 wake-up later, 2 wake-up in the issue cycle
	task automatic issue_op(input bit unit, input int mode, input logic [31:0] val);
		bit used [NTAG];
		int t, p, n;
		bit accepted;
		for (int i = 0; i < NTAG; i++) begin
			used[i] = issued_cnt[i] != done_cnt[i];
		end
		t = find_free(used);
		p = find_free(prod_busy);
		if (t < 0 || p < 0) begin
			give_up("no free ROB tag or producer tag for a new instruction");
		end
		if (mode != 0) begin
			prod_busy[p] = 1'b1;
			prod_val[p] = val;
		end
		n = 0;
		accepted = 1'b0;
		while (!accepted) begin
			if (n == ISSUE_LIMIT) begin
				give_up("issue_ready stayed low and the instruction was never accepted");
			end
			advance();
			// A same-cycle wake-up needs the bus to itself
			if (mode != 2 || !wake_valid) begin
				drive_issue(unit, t[cvt_pkg::ROB_WIDTH-1:0], mode == 0,
					p[cvt_pkg::ROB_WIDTH-1:0], mode == 0 ? val : $urandom);
				if (mode == 2) begin
					wake_valid = 1'b1;
					wake_tag = p[cvt_pkg::ROB_WIDTH-1:0];
					wake_data = val;
				end
				@(negedge clk);
				accepted = is_ready(unit);
			end
			n++;
		end
		exp_data[t] = unit ? ref_itof(val) : ref_ftoi(val);
		exp_dest[t] = unit ? cvt_pkg::DEST_FPR : cvt_pkg::DEST_GPR;
		issued_cnt[t]++;
		if (mode == 1) begin
			pend_q.push_back(p[cvt_pkg::ROB_WIDTH-1:0]);
		end else if (mode == 2) begin
			prod_busy[p] = 1'b0;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (count_outstanding() != 0) begin
			if (n == DRAIN_LIMIT) begin
				give_up("results did not all come back before the drain limit");
			end
			advance();
			n++;
		end
	endtask

	// Silent wake-up bus fills the station with waiting entries
	task automatic fill_station(input bit unit);
		wake_on = 1'b0;
		repeat (cvt_pkg::N_ENTRY) issue_op(unit, 1, rand_value(unit));
		repeat (4) begin
			advance();
			drive_issue(unit, '0, 1'b0, '0, '0);
			@(negedge clk);
			if (unit) begin
				check_val("itof_issue_ready", 32'd0, 32'(itof_issue_ready));
			end else begin
				check_val("ftoi_issue_ready", 32'd0, 32'(ftoi_issue_ready));
			end
		end
		wake_on = 1'b1;
		issue_op(unit, 1, rand_value(unit));
	endtask

	////////////////////////////////////////
	// Result monitor

	initial begin
		bit held;
		logic [cvt_pkg::ROB_WIDTH-1:0] h_tag;
		logic [31:0] h_data;
		cvt_pkg::dest_e h_dest;
		held = 1'b0;
		forever begin
			@(negedge clk);
			if (held) begin  // Back-pressure keeps the bus frozen
				check_val("res_valid", 32'd1, 32'(res_valid));
				check_val("res_tag", 32'(h_tag), 32'(res_tag));
				check_val("res_data", h_data, res_data);
				check_val("res_dest", 32'(h_dest), 32'(res_dest));
			end
			if (!reset && res_valid && res_ready) begin
				check_val("res_tag outstanding", 32'd1,
					32'(issued_cnt[res_tag] - done_cnt[res_tag]));
				check_val("res_data", exp_data[res_tag], res_data);
				check_val("res_dest", 32'(exp_dest[res_tag]), 32'(res_dest));
				done_cnt[res_tag]++;
			end
			held = !reset && res_valid && !res_ready;
			h_tag = res_tag;
			h_data = res_data;
			h_dest = res_dest;
		end
	end

	initial begin
		res_ready = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			res_ready = ($urandom % 4) != 0;
		end
	end

	initial begin
		bit unit;
		void'($urandom(20355));
		reset = 1'b1;
		wake_on = 1'b1;
		ftoi_issue_valid = 1'b0;
		ftoi_issue_tag = '0;
		ftoi_opd_valid = 1'b0;
		ftoi_opd_tag = '0;
		ftoi_opd_data = '0;
		itof_issue_valid = 1'b0;
		itof_issue_tag = '0;
		itof_opd_valid = 1'b0;
		itof_opd_tag = '0;
		itof_opd_data = '0;
		wake_valid = 1'b0;
		wake_tag = '0;
		wake_data = '0;
		for (int i = 0; i < NTAG; i++) begin
			issued_cnt[i] = 0;
			done_cnt[i] = 0;
			prod_busy[i] = 1'b0;
		end
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_val("res_valid", 32'd0, 32'(res_valid));
		check_val("ftoi_issue_ready", 32'd1, 32'(ftoi_issue_ready));
		check_val("itof_issue_ready", 32'd1, 32'(itof_issue_ready));

		foreach (ftoi_vals[i]) issue_op(1'b0, 0, ftoi_vals[i]);
		foreach (itof_vals[i]) issue_op(1'b1, 0, itof_vals[i]);

		// Random mix of units and operand timing
		repeat (400) begin
			unit = 1'($urandom);
			issue_op(unit, $urandom_range(2, 0), rand_value(unit));
		end
		drain();

		fill_station(1'b0);
		drain();
		fill_station(1'b1);
		drain();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: verilog/cvt_cluster.sv
`timescale 1ns/1ps

module cvt_cluster (
	input  logic clk,
	input  logic reset,
	// Float-to-int issue
	input  logic ftoi_issue_valid,
	output logic ftoi_issue_ready,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] ftoi_issue_tag,
	input  logic ftoi_opd_valid,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] ftoi_opd_tag,
	input  logic [31:0] ftoi_opd_data,
	// Int-to-float issue
	input  logic itof_issue_valid,
	output logic itof_issue_ready,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] itof_issue_tag,
	input  logic itof_opd_valid,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] itof_opd_tag,
	input  logic [31:0] itof_opd_data,
	// Wake-up bus
	input  logic wake_valid,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] wake_tag,
	input  logic [31:0] wake_data,
	// Result bus
	output logic res_valid,
	input  logic res_ready,
	output logic [cvt_pkg::ROB_WIDTH-1:0] res_tag,
	output logic [31:0] res_data,
	output cvt_pkg::dest_e res_dest
);
	logic ftoi_req, ftoi_grant;
	logic [cvt_pkg::ROB_WIDTH-1:0] ftoi_sel_tag;
	logic [31:0] ftoi_sel_data, ftoi_result;
	logic itof_req, itof_grant;
	logic [cvt_pkg::ROB_WIDTH-1:0] itof_sel_tag;
	logic [31:0] itof_sel_data, itof_result;

	cvt_station ftoi_rs (
		.clk(clk), .reset(reset),
		.issue_valid(ftoi_issue_valid), .issue_ready(ftoi_issue_ready),
		.issue_tag(ftoi_issue_tag),
		.opd_valid(ftoi_opd_valid), .opd_tag(ftoi_opd_tag), .opd_data(ftoi_opd_data),
		.wake_valid(wake_valid), .wake_tag(wake_tag), .wake_data(wake_data),
		.req(ftoi_req), .grant(ftoi_grant),
		.sel_tag(ftoi_sel_tag), .sel_data(ftoi_sel_data)
	);

	cvt_station itof_rs (
		.clk(clk), .reset(reset),
		.issue_valid(itof_issue_valid), .issue_ready(itof_issue_ready),
		.issue_tag(itof_issue_tag),
		.opd_valid(itof_opd_valid), .opd_tag(itof_opd_tag), .opd_data(itof_opd_data),
		.wake_valid(wake_valid), .wake_tag(wake_tag), .wake_data(wake_data),
		.req(itof_req), .grant(itof_grant),
		.sel_tag(itof_sel_tag), .sel_data(itof_sel_data)
	);

	ftoi_convert ftoi_convert (.a(ftoi_sel_data), .result(ftoi_result));
	itof_convert itof_convert (.a(itof_sel_data), .result(itof_result));

	result_arbiter result_arbiter (
		.clk(clk), .reset(reset),
		.ftoi_req(ftoi_req), .ftoi_grant(ftoi_grant),
		.ftoi_tag(ftoi_sel_tag), .ftoi_data(ftoi_result),
		.itof_req(itof_req), .itof_grant(itof_grant),
		.itof_tag(itof_sel_tag), .itof_data(itof_result),
		.res_valid(res_valid), .res_ready(res_ready),
		.res_tag(res_tag), .res_data(res_data), .res_dest(res_dest)
	);

endmodule

// File: verilog/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic ftoi_req,
	output logic ftoi_grant,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] ftoi_tag,
	input  logic [31:0] ftoi_data,
	input  logic itof_req,
	output logic itof_grant,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] itof_tag,
	input  logic [31:0] itof_data,
	output logic res_valid,
	input  logic res_ready,
	output logic [cvt_pkg::ROB_WIDTH-1:0] res_tag,
	output logic [31:0] res_data,
	output cvt_pkg::dest_e res_dest
);
	cvt_pkg::grant_e last;
	logic load;
	logic pick_itof;
	logic any_grant;

	assign load = !res_valid || res_ready;  // Result register free next cycle

	// On a tie the unit that lost last time goes first
	assign pick_itof = itof_req && (!ftoi_req || last == cvt_pkg::GRANT_FTOI);
	assign ftoi_grant = load && ftoi_req && !pick_itof;
	assign itof_grant = load && pick_itof;
	assign any_grant = ftoi_grant || itof_grant;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			last <= cvt_pkg::GRANT_ITOF;
		end else begin
			if (load) begin
				res_valid <= any_grant;
			end
			if (ftoi_grant) begin
				last <= cvt_pkg::GRANT_FTOI;
			end else if (itof_grant) begin
				last <= cvt_pkg::GRANT_ITOF;
			end
		end
	end

	////////////////////////////////////////
	// Result register, held under back-pressure

	always_ff @(posedge clk) begin
		if (any_grant) begin
			res_tag <= pick_itof ? itof_tag : ftoi_tag;
			res_data <= pick_itof ? itof_data : ftoi_data;
			res_dest <= pick_itof ? cvt_pkg::DEST_FPR : cvt_pkg::DEST_GPR;
		end
	end

endmodule

// File: verilog/itof_convert.sv
`timescale 1ns/1ps

module itof_convert (
	input  logic [31:0] a,
	output logic [31:0] result
);
	logic sign;
	logic [31:0] mag;
	logic [4:0] pos;
	logic [31:0] norm;
	logic guard, sticky, round_up;
	logic [24:0] sum;
	logic [7:0] exp;

	assign sign = a[31];
	assign mag = sign ? -a : a;  // -2^31 stays 0x80000000

	// Leading one
	always_comb begin
		pos = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				pos = i[4:0];
			end
		end
	end

	assign norm = mag << (5'd31 - pos);

	////////////////////////////////////////
	// Round to nearest even

	assign guard = norm[7];
	assign sticky = |norm[6:0];
	assign round_up = guard && (sticky || norm[8]);
	assign sum = {1'b0, norm[31:8]} + {24'd0, round_up};

	// Carry out leaves the fraction at zero either way
	assign exp = 8'd127 + {3'd0, pos} + {7'd0, sum[24]};

	assign result = (mag == 32'd0) ? 32'd0 : {sign, exp, sum[22:0]};

endmodule

// File: verilog/ftoi_convert.sv
`timescale 1ns/1ps

module ftoi_convert (
	input  logic [31:0] a,
	output logic [31:0] result
);
	logic sign;
	logic [7:0] exp;
	logic [22:0] frac;
	logic [7:0] shamt;
	logic [63:0] fixed;  // Integer in [63:32], fraction below
	logic [31:0] mag;

	assign sign = a[31];
	assign exp = a[30:23];
	assign frac = a[22:0];

	// Only meaningful for exponents 126 to 157
	assign shamt = 8'd158 - exp;
	assign fixed = {1'b1, frac, 40'd0} >> shamt;

	// Half bit set rounds the magnitude up, so ties go away from zero
	assign mag = fixed[63:32] + {31'd0, fixed[31]};

	always_comb begin
		if (exp == 8'hff && frac != 23'd0) begin
			result = 32'h7fff_ffff;  // NaN
		end else if (exp >= 8'd158) begin
			// Covers infinity, and -2^31 lands on the minimum exactly
			result = sign ? 32'h8000_0000 : 32'h7fff_ffff;
		end else if (exp < 8'd126) begin
			result = 32'd0;  // Below one half, zero and denormals
		end else begin
			result = sign ? -mag : mag;
		end
	end

endmodule

// File: verilog/cvt_station.sv
`timescale 1ns/1ps

module cvt_station (
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	output logic issue_ready,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] issue_tag,
	input  logic opd_valid,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] opd_tag,
	input  logic [31:0] opd_data,
	input  logic wake_valid,
	input  logic [cvt_pkg::ROB_WIDTH-1:0] wake_tag,
	input  logic [31:0] wake_data,
	output logic req,
	input  logic grant,
	output logic [cvt_pkg::ROB_WIDTH-1:0] sel_tag,
	output logic [31:0] sel_data
);
	// Entries fill from 0 upward
	logic [cvt_pkg::N_ENTRY-1:0] ent_valid, ent_rdy;
	logic [cvt_pkg::ROB_WIDTH-1:0] ent_tag [cvt_pkg::N_ENTRY];
	logic [cvt_pkg::ROB_WIDTH-1:0] ent_opd_tag [cvt_pkg::N_ENTRY];
	logic [31:0] ent_data [cvt_pkg::N_ENTRY];

	logic [cvt_pkg::N_ENTRY-1:0] upd_rdy;
	logic [31:0] upd_data [cvt_pkg::N_ENTRY];

	logic [cvt_pkg::N_ENTRY-1:0] nxt_valid, nxt_rdy;
	logic [cvt_pkg::ROB_WIDTH-1:0] nxt_tag [cvt_pkg::N_ENTRY];
	logic [cvt_pkg::ROB_WIDTH-1:0] nxt_opd_tag [cvt_pkg::N_ENTRY];
	logic [31:0] nxt_data [cvt_pkg::N_ENTRY];

	logic new_rdy;
	logic [31:0] new_data;
	logic sel;
	logic dispatch;

	// Incoming operand may be caught on the wake-up bus in the issue cycle
	assign new_rdy = opd_valid || (wake_valid && wake_tag == opd_tag);
	assign new_data = opd_valid ? opd_data : wake_data;

	for (genvar i = 0; i < cvt_pkg::N_ENTRY; i++) begin : g_wake
		assign upd_rdy[i] = ent_rdy[i] || (wake_valid && wake_tag == ent_opd_tag[i]);
		assign upd_data[i] = ent_rdy[i] ? ent_data[i] : wake_data;
	end

	assign sel = !(ent_valid[0] && ent_rdy[0]);  // Oldest ready entry
	assign req = |(ent_valid & ent_rdy);
	assign sel_tag = ent_tag[sel];
	assign sel_data = ent_data[sel];
	assign dispatch = req && grant;
	assign issue_ready = dispatch || !ent_valid[cvt_pkg::N_ENTRY-1];

	////////////////////////////////////////
	// Next state with compaction

	always_comb begin
		for (int i = 0; i < cvt_pkg::N_ENTRY; i++) begin
			nxt_valid[i] = ent_valid[i];
			nxt_tag[i] = ent_tag[i];
			nxt_rdy[i] = upd_rdy[i];
			nxt_opd_tag[i] = ent_opd_tag[i];
			nxt_data[i] = upd_data[i];
		end

		if (dispatch && !sel && ent_valid[1]) begin
			nxt_valid[0] = 1'b1;  // Entry 1 slides down
			nxt_tag[0] = ent_tag[1];
			nxt_rdy[0] = upd_rdy[1];
			nxt_opd_tag[0] = ent_opd_tag[1];
			nxt_data[0] = upd_data[1];
		end else if (dispatch ? (!sel && !ent_valid[1]) : !ent_valid[0]) begin
			nxt_valid[0] = issue_valid;
			nxt_tag[0] = issue_tag;
			nxt_rdy[0] = new_rdy;
			nxt_opd_tag[0] = opd_tag;
			nxt_data[0] = new_data;
		end

		if (dispatch ? ent_valid[1] : (ent_valid[0] && !ent_valid[1])) begin
			nxt_valid[1] = issue_valid;
			nxt_tag[1] = issue_tag;
			nxt_rdy[1] = new_rdy;
			nxt_opd_tag[1] = opd_tag;
			nxt_data[1] = new_data;
		end else if (dispatch) begin
			nxt_valid[1] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		ent_rdy <= nxt_rdy;
		for (int i = 0; i < cvt_pkg::N_ENTRY; i++) begin
			ent_tag[i] <= nxt_tag[i];
			ent_opd_tag[i] <= nxt_opd_tag[i];
			ent_data[i] <= nxt_data[i];
		end
	end

endmodule

// File: verilog/cvt_pkg.sv
package cvt_pkg;

	////////////////////////////////////////
	// Sizes

	localparam int ROB_WIDTH = 4;  // 16 tags in flight
	localparam int N_ENTRY = 2;    // Reservation station depth

	////////////////////////////////////////
	// Enums

	// Register file that receives a result
	typedef enum logic {
		DEST_GPR = 1'b0,
		DEST_FPR = 1'b1
	} dest_e;

	// Last winner of the result bus
	typedef enum logic {
		GRANT_FTOI = 1'b0,
		GRANT_ITOF = 1'b1
	} grant_e;

endpackage
